//--- hw/fe_defs.svh
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// ----------------------------------------
// frontend widths and constants
// ----------------------------------------

// width of every address and of one instruction word
`define FE_VLEN 32

// number of entries held toward decode
`define FE_QUEUE_DEPTH 4

// byte step between sequential fetches
// also the offset added to the commit pc on a commit redirect
`define FE_PC_STEP 4

// fixed fetch address on debug entry
`define FE_DEBUG_ADDR 32'h0000_0800

`endif

//--- hw/fe_pkg.sv
package fe_pkg;

    // ----------------------------------------
    // major opcodes seen by the fetch scan
    // ----------------------------------------
    // every other opcode is an ordinary instruction
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } rv_opcode_e;

    // ----------------------------------------
    // control-flow class of a queue entry
    // ----------------------------------------
    typedef enum logic [1:0] {
        // plain instruction or branch predicted not taken
        CF_NONE   = 2'd0,
        // conditional branch predicted taken
        CF_BRANCH = 2'd1,
        // jal, always taken
        CF_JUMP   = 2'd2,
        // jalr, target left to the backend
        CF_JUMPR  = 2'd3
    } cf_e;

    // ----------------------------------------
    // fetch exception
    // ----------------------------------------
    // the memory reports the same codes on its error lines
    typedef enum logic [1:0] {
        FE_NONE         = 2'd0,
        FE_PAGE_FAULT   = 2'd1,
        FE_ACCESS_FAULT = 2'd2
    } fe_ex_e;

endpackage

//--- hw/fe_pc_gen.sv
`timescale 1ns/10ps
`include "fe_defs.svh"

module fe_pc_gen import fe_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic [`FE_VLEN-1:0] boot_addr_i,
    // redirect sources
    input  logic                mispredict_i,
    input  logic [`FE_VLEN-1:0] mispredict_target_i,
    input  logic                eret_i,
    input  logic [`FE_VLEN-1:0] epc_i,
    input  logic                ex_valid_i,
    input  logic [`FE_VLEN-1:0] trap_vector_i,
    input  logic                set_pc_commit_i,
    input  logic [`FE_VLEN-1:0] pc_commit_i,
    input  logic                set_debug_pc_i,
    // queue state and replay
    input  logic                queue_ready_i,
    input  logic                replay_i,
    input  logic [`FE_VLEN-1:0] replay_pc_i,
    // taken prediction from the predecoder
    input  logic                bp_valid_i,
    input  logic [`FE_VLEN-1:0] bp_target_i,
    // instruction memory
    input  logic                icache_ready_i,
    output logic                icache_req_o,
    output logic [`FE_VLEN-1:0] icache_addr_o,
    output logic                icache_kill_o
);

    // next fetch address
    logic [`FE_VLEN-1:0] npc_d;
    logic [`FE_VLEN-1:0] npc_q;
    // set while coming out of reset so the boot address gets loaded
    logic                npc_rst_load_q;
    // address presented this cycle
    logic [`FE_VLEN-1:0] fetch_addr;
    logic                kill;
    logic                fetch_accept;

    // ----------------------------------------
    // request and kill
    // ----------------------------------------
    // no request while the queue is full or the boot address is loading
    assign icache_req_o = queue_ready_i & ~npc_rst_load_q;

    // wrong-path fetches get killed on
    //   flush, mispredict, replay of a refused push, taken prediction
    assign kill          = flush_i | mispredict_i | replay_i | bp_valid_i;
    assign icache_kill_o = kill;

    // a killed request is never answered and does not count
    assign fetch_accept = icache_req_o & icache_ready_i & ~kill;

    assign icache_addr_o = fetch_addr;

    // ----------------------------------------
    // next pc selection
    // ----------------------------------------
    // lowest priority first so that later assignments win
    always_comb begin : npc_select
        if (npc_rst_load_q) begin
            fetch_addr = boot_addr_i;
            npc_d      = boot_addr_i;
        end else begin
            fetch_addr = npc_q;
            // hold by default
            npc_d      = npc_q;
        end
        // predicted target replaces the current address
        if (bp_valid_i) begin
            fetch_addr = bp_target_i;
            npc_d      = bp_target_i;
        end
        // word-aligned sequential step
        if (fetch_accept) begin
            npc_d = {fetch_addr[`FE_VLEN-1:2], 2'b00} + `FE_VLEN'(`FE_PC_STEP);
        end
        // refetch the instruction the queue refused
        if (replay_i) begin
            npc_d = replay_pc_i;
        end
        // resolved branch went the other way
        if (mispredict_i) begin
            npc_d = mispredict_target_i;
        end
        // return from trap
        if (eret_i) begin
            npc_d = epc_i;
        end
        // exception or interrupt
        if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end
        // restart after the instruction in commit
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + `FE_VLEN'(`FE_PC_STEP);
        end
        // debug entry has the top priority
        if (set_debug_pc_i) begin
            npc_d = `FE_DEBUG_ADDR;
        end
    end

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
        end
    end

endmodule

//--- hw/fe_predecode.sv
`timescale 1ns/10ps
`include "fe_defs.svh"

module fe_predecode import fe_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    // kill from the pc generator, discards the response of this cycle
    input  logic                drop_i,
    // instruction memory response
    input  logic                icache_valid_i,
    input  logic [`FE_VLEN-1:0] icache_addr_i,
    input  logic [`FE_VLEN-1:0] icache_data_i,
    input  logic [1:0]          icache_err_i,
    // one-cycle push toward the queue
    output logic                dec_valid_o,
    output logic [`FE_VLEN-1:0] dec_instr_o,
    output logic [`FE_VLEN-1:0] dec_pc_o,
    output cf_e                 dec_cf_o,
    output fe_ex_e              dec_ex_o,
    // taken prediction
    output logic                bp_valid_o,
    output logic [`FE_VLEN-1:0] bp_target_o
);

    // address of last cycle's request, lines up with the response
    logic [`FE_VLEN-1:0] req_addr_q;
    // registered response
    logic                valid_q;
    logic [`FE_VLEN-1:0] instr_q;
    logic [`FE_VLEN-1:0] pc_q;
    fe_ex_e              ex_d;
    fe_ex_e              ex_q;
    // scan results
    rv_opcode_e          opcode;
    logic [`FE_VLEN-1:0] imm_b;
    logic [`FE_VLEN-1:0] imm_j;
    logic [`FE_VLEN-1:0] imm;
    cf_e                 cf;

    // ----------------------------------------
    // response capture
    // ----------------------------------------
    // 2'b11 carries no defined fault
    always_comb begin
        case (icache_err_i)
            FE_PAGE_FAULT:   ex_d = FE_PAGE_FAULT;
            FE_ACCESS_FAULT: ex_d = FE_ACCESS_FAULT;
            default:         ex_d = FE_NONE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= icache_valid_i & ~drop_i;
        end
    end

    always_ff @(posedge clk_i) begin
        req_addr_q <= icache_addr_i;
        if (icache_valid_i && !drop_i) begin
            instr_q <= icache_data_i;
            pc_q    <= req_addr_q;
            ex_q    <= ex_d;
        end
    end

    // ----------------------------------------
    // opcode scan and static prediction
    // ----------------------------------------
    assign opcode = rv_opcode_e'(instr_q[6:0]);

    // B-type and J-type immediates, sign extended
    assign imm_b = {{(`FE_VLEN-12){instr_q[31]}}, instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_j = {{(`FE_VLEN-20){instr_q[31]}}, instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        cf  = CF_NONE;
        imm = imm_b;
        // a faulted word holds no usable instruction
        if (ex_q == FE_NONE) begin
            case (opcode)
                OPC_JAL: begin
                    cf  = CF_JUMP;
                    imm = imm_j;
                end
                // backward branch taken, forward not taken
                OPC_BRANCH: cf = imm_b[`FE_VLEN-1] ? CF_BRANCH : CF_NONE;
                // target unknown here
                OPC_JALR: cf = CF_JUMPR;
                default: cf = CF_NONE;
            endcase
        end
    end

    assign bp_valid_o  = valid_q & ((cf == CF_BRANCH) | (cf == CF_JUMP));
    assign bp_target_o = pc_q + imm;

    assign dec_valid_o = valid_q;
    assign dec_instr_o = instr_q;
    assign dec_pc_o    = pc_q;
    assign dec_cf_o    = cf;
    assign dec_ex_o    = ex_q;

endmodule

//--- hw/fe_instr_queue.sv
`timescale 1ns/10ps
`include "fe_defs.svh"

module fe_instr_queue import fe_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    // push side, one-cycle strobe
    input  logic                push_i,
    input  logic [`FE_VLEN-1:0] push_instr_i,
    input  logic [`FE_VLEN-1:0] push_pc_i,
    input  cf_e                 push_cf_i,
    input  logic [`FE_VLEN-1:0] push_target_i,
    input  fe_ex_e              push_ex_i,
    output logic                queue_ready_o,
    // refused push, refetch from replay_pc_o
    output logic                replay_o,
    output logic [`FE_VLEN-1:0] replay_pc_o,
    // decode side
    input  logic                entry_ready_i,
    output logic                entry_valid_o,
    output logic [`FE_VLEN-1:0] entry_instr_o,
    output logic [`FE_VLEN-1:0] entry_pc_o,
    output cf_e                 entry_cf_o,
    output logic [`FE_VLEN-1:0] entry_target_o,
    output fe_ex_e              entry_ex_o
);

    localparam int PTR_W = (`FE_QUEUE_DEPTH > 1) ? $clog2(`FE_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`FE_QUEUE_DEPTH + 1);

    // entry storage
    logic [`FE_VLEN-1:0] instr_mem  [`FE_QUEUE_DEPTH];
    logic [`FE_VLEN-1:0] pc_mem     [`FE_QUEUE_DEPTH];
    cf_e                 cf_mem     [`FE_QUEUE_DEPTH];
    logic [`FE_VLEN-1:0] target_mem [`FE_QUEUE_DEPTH];
    fe_ex_e              ex_mem     [`FE_QUEUE_DEPTH];

    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                full;
    logic                push_ok;
    logic                pop;

    // wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FE_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full          = (count_q == CNT_W'(`FE_QUEUE_DEPTH));
    assign queue_ready_o = ~full;

    // a flush drops whatever arrives with it
    assign push_ok = push_i & ~full & ~flush_i;
    assign pop     = entry_valid_o & entry_ready_i;

    // full queue turns the push into a replay of that pc
    assign replay_o    = push_i & full & ~flush_i;
    assign replay_pc_o = push_pc_i;

    // ----------------------------------------
    // pointers and count
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // push and pop together keep the count
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            instr_mem[wr_ptr_q]  <= push_instr_i;
            pc_mem[wr_ptr_q]     <= push_pc_i;
            cf_mem[wr_ptr_q]     <= push_cf_i;
            target_mem[wr_ptr_q] <= push_target_i;
            ex_mem[wr_ptr_q]     <= push_ex_i;
        end
    end

    // head entry, stays put until it is popped
    assign entry_valid_o  = (count_q != '0);
    assign entry_instr_o  = instr_mem[rd_ptr_q];
    assign entry_pc_o     = pc_mem[rd_ptr_q];
    assign entry_cf_o     = cf_mem[rd_ptr_q];
    assign entry_target_o = target_mem[rd_ptr_q];
    assign entry_ex_o     = ex_mem[rd_ptr_q];

endmodule

//--- hw/frontend.sv
`timescale 1ns/10ps
`include "fe_defs.svh"

module frontend import fe_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic [`FE_VLEN-1:0] boot_addr_i,
    // redirects from the backend
    input  logic                mispredict_i,
    input  logic [`FE_VLEN-1:0] mispredict_target_i,
    input  logic                eret_i,
    input  logic [`FE_VLEN-1:0] epc_i,
    input  logic                ex_valid_i,
    input  logic [`FE_VLEN-1:0] trap_vector_i,
    input  logic                set_pc_commit_i,
    input  logic [`FE_VLEN-1:0] pc_commit_i,
    input  logic                set_debug_pc_i,
    // instruction memory
    output logic                icache_req_o,
    output logic [`FE_VLEN-1:0] icache_addr_o,
    output logic                icache_kill_o,
    input  logic                icache_ready_i,
    input  logic                icache_valid_i,
    input  logic [`FE_VLEN-1:0] icache_data_i,
    input  logic [1:0]          icache_err_i,
    // toward decode
    output logic                entry_valid_o,
    input  logic                entry_ready_i,
    output logic [`FE_VLEN-1:0] entry_instr_o,
    output logic [`FE_VLEN-1:0] entry_pc_o,
    output cf_e                 entry_cf_o,
    output logic [`FE_VLEN-1:0] entry_target_o,
    output fe_ex_e              entry_ex_o
);

    logic                queue_ready;
    logic                replay;
    logic [`FE_VLEN-1:0] replay_pc;
    // predecoder to queue
    logic                dec_valid;
    logic [`FE_VLEN-1:0] dec_instr;
    logic [`FE_VLEN-1:0] dec_pc;
    cf_e                 dec_cf;
    fe_ex_e              dec_ex;
    logic                bp_valid;
    logic [`FE_VLEN-1:0] bp_target;

    fe_pc_gen i_pc_gen (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .flush_i             ( flush_i             ),
        .boot_addr_i         ( boot_addr_i         ),
        .mispredict_i        ( mispredict_i        ),
        .mispredict_target_i ( mispredict_target_i ),
        .eret_i              ( eret_i              ),
        .epc_i               ( epc_i               ),
        .ex_valid_i          ( ex_valid_i          ),
        .trap_vector_i       ( trap_vector_i       ),
        .set_pc_commit_i     ( set_pc_commit_i     ),
        .pc_commit_i         ( pc_commit_i         ),
        .set_debug_pc_i      ( set_debug_pc_i      ),
        .queue_ready_i       ( queue_ready         ),
        .replay_i            ( replay              ),
        .replay_pc_i         ( replay_pc           ),
        .bp_valid_i          ( bp_valid            ),
        .bp_target_i         ( bp_target           ),
        .icache_ready_i      ( icache_ready_i      ),
        .icache_req_o        ( icache_req_o        ),
        .icache_addr_o       ( icache_addr_o       ),
        .icache_kill_o       ( icache_kill_o       )
    );

    // request address goes in here, lined up with the response inside
    fe_predecode i_predecode (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .drop_i         ( icache_kill_o  ),
        .icache_valid_i ( icache_valid_i ),
        .icache_addr_i  ( icache_addr_o  ),
        .icache_data_i  ( icache_data_i  ),
        .icache_err_i   ( icache_err_i   ),
        .dec_valid_o    ( dec_valid      ),
        .dec_instr_o    ( dec_instr      ),
        .dec_pc_o       ( dec_pc         ),
        .dec_cf_o       ( dec_cf         ),
        .dec_ex_o       ( dec_ex         ),
        .bp_valid_o     ( bp_valid       ),
        .bp_target_o    ( bp_target      )
    );

    fe_instr_queue i_instr_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .push_i         ( dec_valid      ),
        .push_instr_i   ( dec_instr      ),
        .push_pc_i      ( dec_pc         ),
        .push_cf_i      ( dec_cf         ),
        .push_target_i  ( bp_target      ),
        .push_ex_i      ( dec_ex         ),
        .queue_ready_o  ( queue_ready    ),
        .replay_o       ( replay         ),
        .replay_pc_o    ( replay_pc      ),
        .entry_ready_i  ( entry_ready_i  ),
        .entry_valid_o  ( entry_valid_o  ),
        .entry_instr_o  ( entry_instr_o  ),
        .entry_pc_o     ( entry_pc_o     ),
        .entry_cf_o     ( entry_cf_o     ),
        .entry_target_o ( entry_target_o ),
        .entry_ex_o     ( entry_ex_o     )
    );

endmodule

//--- test/frontend_tb.sv
`timescale 1ns/10ps
`include "fe_defs.svh"

module frontend_tb import fe_pkg::*; ();

    localparam int          CLK_PERIOD  = 100;
    localparam int          NUM_PHASES  = 4;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_1000;
    localparam logic [31:0] MISP_TARGET = 32'h0000_2000;
    localparam logic [31:0] EPC_ADDR    = 32'h0000_3000;
    localparam logic [31:0] TRAP_VECTOR = 32'h0000_4000;
    localparam logic [31:0] COMMIT_PC   = 32'h0000_5000;

    logic clk_i, rst_ni, flush_i;
    logic [31:0] boot_addr_i;
    logic mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, set_debug_pc_i;
    logic [31:0] mispredict_target_i, epc_i, trap_vector_i, pc_commit_i;
    logic icache_req_o, icache_kill_o, icache_ready_i, icache_valid_i;
    logic [31:0] icache_addr_o, icache_data_i;
    logic [1:0] icache_err_i;
    logic entry_valid_o, entry_ready_i;
    logic [31:0] entry_instr_o, entry_pc_o, entry_target_o;
    cf_e entry_cf_o;
    fe_ex_e entry_ex_o;

    // program table, keyed by byte address
    logic [31:0] prog_word [bit [31:0]];
    logic [31:0] prog_off  [bit [31:0]];
    cf_e         prog_cf   [bit [31:0]];
    fe_ex_e      prog_ex   [bit [31:0]];

    // stimulus state
    logic        long_stalls;
    int          stall_cnt;
    int          pop_count = 0;
    // reference model state
    logic        seen_edge = 1'b0;
    logic        accept, seq_active, redir_pending, hold, prev_flush;
    logic [31:0] seq_addr, redir_addr, exp_pc;
    logic [99:0] hold_fields;

    frontend UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------
    // program contents
    // ----------------------------------------
    function automatic void put_jal(input logic [31:0] a, input logic [31:0] off);
        prog_word[a] = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b110_1111};
        prog_cf[a]   = CF_JUMP;
        prog_off[a]  = off;
    endfunction

    // beq x1, x2, only backward ones count as taken
    function automatic void put_branch(input logic [31:0] a, input logic [31:0] off);
        prog_word[a] = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b110_0011};
        prog_cf[a]   = off[31] ? CF_BRANCH : CF_NONE;
        prog_off[a]  = off;
    endfunction

    function automatic void put_jalr(input logic [31:0] a);
        prog_word[a] = {12'd0, 5'd1, 3'b000, 5'd0, 7'b110_0111};
        prog_cf[a]   = CF_JUMPR;
    endfunction

    function automatic void load_program();
        put_branch(32'h1008, 32'd16);
        put_jalr(32'h100C);
        prog_ex[32'h1014] = FE_PAGE_FAULT;
        // a jal that faults must not be predicted
        put_jal(32'h1018, 32'h100);
        prog_ex[32'h1018] = FE_ACCESS_FAULT;
        put_jal(32'h101C, 32'h24);
        put_branch(32'h1050, -32'd48);
        // tight loop after a mispredict
        put_jal(32'h2008, -32'd8);
        put_branch(32'h3010, 32'd8);
        put_branch(32'h3020, -32'd28);
        prog_ex[32'h4004] = FE_PAGE_FAULT;
        put_jal(32'h400C, 32'h40);
        put_jal(32'h4058, -32'd88);
        put_jalr(32'h5010);
        put_branch(32'h5018, -32'd20);
        prog_ex[32'h0808] = FE_ACCESS_FAULT;
        put_jal(32'h0810, -32'd16);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (prog_word.exists(a)) begin
            return prog_word[a];
        end
        // ordinary op-imm, immediate bits spread over the whole address
        return {a[31:7] ^ {a[6:2], a[26:7]}, 7'b001_0011};
    endfunction

    function automatic fe_ex_e ex_at(input logic [31:0] a);
        return prog_ex.exists(a) ? prog_ex[a] : FE_NONE;
    endfunction

    function automatic cf_e cf_at(input logic [31:0] a);
        if (ex_at(a) != FE_NONE) begin
            return CF_NONE;
        end
        return prog_cf.exists(a) ? prog_cf[a] : CF_NONE;
    endfunction

    // walk rule: taken jal and backward branch go to pc + offset
    function automatic logic [31:0] next_pc(input logic [31:0] a);
        if (cf_at(a) == CF_BRANCH || cf_at(a) == CF_JUMP) begin
            return a + prog_off[a];
        end
        return a + `FE_PC_STEP;
    endfunction

    // highest pending redirect source wins
    function automatic logic [31:0] redirect_target();
        if (set_debug_pc_i) return `FE_DEBUG_ADDR;
        if (set_pc_commit_i) return pc_commit_i + `FE_PC_STEP;
        if (ex_valid_i) return trap_vector_i;
        if (eret_i) return epc_i;
        return mispredict_target_i;
    endfunction

    // ----------------------------------------
    // error reporting
    // ----------------------------------------
    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_error($sformatf("Fail %0t: %s", $time, msg));
    endtask

    // ----------------------------------------
    // memory model and ready generation
    // ----------------------------------------
    always @(posedge clk_i) begin
        // answer accepted fetches one cycle later
        if (rst_ni && icache_req_o && icache_ready_i && !icache_kill_o) begin
            icache_valid_i <= 1'b1;
            icache_data_i  <= word_at(icache_addr_o);
            icache_err_i   <= ex_at(icache_addr_o);
        end else begin
            icache_valid_i <= 1'b0;
        end
        icache_ready_i <= ($urandom % 4) != 0;
        if (stall_cnt != 0) begin
            entry_ready_i <= 1'b0;
            stall_cnt     <= stall_cnt - 1;
        end else begin
            entry_ready_i <= ($urandom % 4) != 0;
            if (long_stalls && ($urandom % 8) == 0) begin
                stall_cnt <= 8 + $urandom % 13;
            end
        end
    end

    // ----------------------------------------
    // reference model and checks
    // ----------------------------------------
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if (seen_edge) begin
                assert (!icache_req_o && !icache_kill_o && !entry_valid_o)
                    else report_mismatch("outputs active during reset");
            end
            seen_edge     = 1'b1;
            seq_active    = 1'b1;
            seq_addr      = boot_addr_i;
            exp_pc        = boot_addr_i;
            redir_pending = 1'b0;
            hold          = 1'b0;
            prev_flush    = 1'b0;
        end else begin
            accept = icache_req_o && icache_ready_i && !icache_kill_o;
            // straight-line fetch from boot until the first kill
            if (icache_kill_o) begin
                seq_active = 1'b0;
            end else if (accept && seq_active) begin
                assert (icache_addr_o == seq_addr) else report_mismatch(
                    $sformatf("fetch addr %h, expected %h", icache_addr_o, seq_addr));
                seq_addr = seq_addr + `FE_PC_STEP;
            end
            if (accept && redir_pending) begin
                assert (icache_addr_o == redir_addr) else report_mismatch(
                    $sformatf("redirect fetch %h, expected %h", icache_addr_o, redir_addr));
                redir_pending = 1'b0;
            end
            // a stalled head keeps every field
            if (hold) begin
                assert (entry_valid_o && hold_fields == {entry_instr_o, entry_pc_o,
                        entry_cf_o, entry_target_o, entry_ex_o})
                    else report_mismatch("entry changed while stalled");
            end
            if (prev_flush) begin
                assert (!entry_valid_o) else report_mismatch("entry valid after flush");
            end
            if (entry_valid_o && entry_ready_i) begin
                assert (entry_pc_o == exp_pc) else report_mismatch(
                    $sformatf("entry pc %h, expected %h", entry_pc_o, exp_pc));
                assert (entry_instr_o == word_at(exp_pc)) else report_mismatch(
                    $sformatf("instr %h at pc %h", entry_instr_o, exp_pc));
                assert (entry_cf_o == cf_at(exp_pc)) else report_mismatch(
                    $sformatf("cf %0d at pc %h", entry_cf_o, exp_pc));
                assert (entry_ex_o == ex_at(exp_pc)) else report_mismatch(
                    $sformatf("exception %0d at pc %h", entry_ex_o, exp_pc));
                if (cf_at(exp_pc) == CF_BRANCH || cf_at(exp_pc) == CF_JUMP) begin
                    assert (entry_target_o == exp_pc + prog_off[exp_pc]) else report_mismatch(
                        $sformatf("target %h at pc %h", entry_target_o, exp_pc));
                end
                exp_pc = next_pc(exp_pc);
                pop_count <= pop_count + 1;
            end
            hold        = entry_valid_o && !entry_ready_i && !flush_i;
            hold_fields = {entry_instr_o, entry_pc_o, entry_cf_o, entry_target_o, entry_ex_o};
            prev_flush  = flush_i;
            // every flush carries a redirect, walk restarts there
            if (flush_i) begin
                redir_addr    = redirect_target();
                redir_pending = 1'b1;
                exp_pc        = redir_addr;
            end
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic wait_pops(input int n);
        int target;
        target = pop_count + n;
        while (pop_count < target) begin
            @(posedge clk_i);
        end
    endtask

    // sel is {debug, commit, exception, eret, mispredict}
    task automatic pulse_redirect(input logic [4:0] sel);
        @(posedge clk_i);
        flush_i         <= 1'b1;
        mispredict_i    <= sel[0];
        eret_i          <= sel[1];
        ex_valid_i      <= sel[2];
        set_pc_commit_i <= sel[3];
        set_debug_pc_i  <= sel[4];
        @(posedge clk_i);
        {flush_i, mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, set_debug_pc_i} <= '0;
    endtask

    initial begin
        void'($urandom(32'h69377193));
        clk_i = 1'b0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        boot_addr_i = BOOT_ADDR;
        {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, set_debug_pc_i} = '0;
        mispredict_target_i = MISP_TARGET;
        epc_i = EPC_ADDR;
        trap_vector_i = TRAP_VECTOR;
        pc_commit_i = COMMIT_PC;
        icache_ready_i = 1'b0;
        icache_valid_i = 1'b0;
        icache_data_i = '0;
        icache_err_i = '0;
        entry_ready_i = 1'b0;
        long_stalls = 1'b0;
        stall_cnt = 0;
        load_program();
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        // free run from boot
        wait_pops(40);
        // long decode stalls force replays
        long_stalls <= 1'b1;
        wait_pops(24);
        long_stalls <= 1'b0;
        // each redirect source alone
        for (int i = 0; i < 5; i++) begin
            pulse_redirect(5'(1 << i));
            wait_pops(8);
        end
        // several sources in one cycle
        for (int i = 0; i < 6; i++) begin
            pulse_redirect(5'($urandom % 31) + 5'd1);
            wait_pops(8);
        end
        repeat (4) @(posedge clk_i);
        $display("Simulation passed");
        $finish;
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * 200 * NUM_PHASES);
        stop_with_error("timeout: the test phases did not finish in time");
    end

endmodule

//--- frontend.f
+incdir+hw
hw/fe_pkg.sv
hw/fe_pc_gen.sv
hw/fe_predecode.sv
hw/fe_instr_queue.sv
hw/frontend.sv
test/frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frontend testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f frontend.f --top-module frontend_tb -o frontend_sim

# the pipe keeps going on a non-zero exit, the log decides
./obj_dir/frontend_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "result: FAILED"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "result: no pass line in sim.log"
    exit 1
fi
echo "result: PASSED"
